//--- cw_bridge_top.f
logic/cw_pkg.sv
logic/cw_link_if.sv
logic/cw_header_pack.sv
logic/cw_burst_tracker.sv
logic/cw_bridge_ctrl.sv
logic/cw_remote_endpoint.sv
logic/cw_bridge_top.sv
sim/cw_bridge_assert.sv
sim/cw_bridge_tb.sv

//--- logic/cw_bridge_ctrl.sv
`default_nettype none

module cw_bridge_ctrl (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              wb_cyc_i,
    input  logic              wb_stb_i,
    input  logic              wb_we_i,
    input  cw_pkg::word_t     wb_dat_i,
    input  cw_pkg::word_t     hdr_i,
    input  cw_pkg::word_t     adr_lo_i,
    input  logic              last_i,
    input  logic              mismatch_i,
    output cw_pkg::word_t     wb_dat_o,
    output logic              wb_ack_o,
    output logic              wb_err_o,
    output logic              start_o,
    output logic              beat_o,
    cw_link_if.master         link
);
    import cw_pkg::*;

    cw_state_e state;
    logic      l_we;           // direction of the running cycle
    logic      xfer_ack;

    assign xfer_ack = link.ack && wb_cyc_i && wb_stb_i;
    assign start_o  = (state == ST_IDLE) && wb_cyc_i && wb_stb_i;
    assign beat_o   = ((state == ST_DATA_W) || (state == ST_DATA_R)) && xfer_ack;

    // ======================================================================
    // link sequencing FSM
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state    <= ST_IDLE;
            wb_ack_o <= 1'b0;
            wb_err_o <= 1'b0;
            link.req <= 1'b0;
            link.dir <= 1'b0;
        end else begin
            wb_ack_o <= 1'b0;      // ack and err are single-cycle pulses
            wb_err_o <= 1'b0;
            link.req <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (start_o) begin
                        link.req   <= 1'b1;
                        link.dat_m <= hdr_i;
                        l_we       <= wb_we_i;
                        state      <= ST_HDR;
                    end
                end
                ST_HDR: begin
                    link.dat_m <= adr_lo_i;     // low address word follows header
                    state      <= ST_ADR;
                end
                ST_ADR: begin
                    state <= ST_WACK;
                end
                ST_WACK: begin
                    if (link.err) begin                     // out of range
                        wb_err_o <= 1'b1;
                        state    <= ST_DONE;
                    end else if (link.ack) begin
                        if (l_we) begin
                            link.req   <= 1'b1;             // first write beat
                            link.dat_m <= wb_dat_i;
                            state      <= ST_DATA_W;
                        end else begin
                            link.dir <= 1'b1;               // endpoint takes the bus
                            state    <= ST_DATA_R;
                        end
                    end
                end
                ST_DATA_W: begin
                    if (xfer_ack) begin
                        if (mismatch_i) begin
                            wb_err_o <= 1'b1;
                            link.dir <= 1'b1;               // turnaround ends the write
                            state    <= ST_DONE;
                        end else begin
                            wb_ack_o <= 1'b1;
                            if (last_i) begin
                                link.dir <= 1'b1;
                                state    <= ST_DONE;
                            end else begin
                                state <= ST_DATA_WT;
                            end
                        end
                    end
                end
                ST_DATA_WT: begin
                    // the master drops stb after each ack and comes back with new data
                    if (wb_cyc_i && wb_stb_i && !wb_ack_o) begin
                        link.req   <= 1'b1;
                        link.dat_m <= wb_dat_i;
                        state      <= ST_DATA_W;
                    end
                end
                ST_DATA_R: begin
                    if (xfer_ack) begin
                        if (mismatch_i) begin
                            wb_err_o <= 1'b1;
                            link.dir <= 1'b0;               // stops endpoint pacing
                            state    <= ST_DONE;
                        end else begin
                            wb_ack_o <= 1'b1;               // registered, no comb path
                            wb_dat_o <= link.dat_s;
                            if (last_i) begin
                                link.dir <= 1'b0;
                                state    <= ST_DONE;
                            end
                        end
                    end
                end
                ST_DONE: begin
                    link.dir <= 1'b0;
                    state    <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/cw_bridge_top.sv
`default_nettype none

module cw_bridge_top (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             wb_cyc_i,
    input  logic             wb_stb_i,
    input  logic             wb_we_i,
    input  cw_pkg::wb_addr_t wb_adr_i,
    input  cw_pkg::word_t    wb_dat_i,
    input  cw_pkg::sel_t     wb_sel_i,
    input  logic             wb_burst8_i,
    input  logic             wb_burst4_i,
    output cw_pkg::word_t    wb_dat_o,
    output logic             wb_ack_o,
    output logic             wb_err_o
);
    import cw_pkg::*;

    word_t     hdr;
    word_t     adr_lo;
    beat_cnt_t last_beat;
    logic      last;
    logic      mismatch;
    logic      start;
    logic      beat;

    cw_link_if link_if ();

    // ======================================================================
    // bridge side
    // ======================================================================
    cw_header_pack u_header_pack (
        .wb_adr_i    (wb_adr_i),
        .wb_we_i     (wb_we_i),
        .wb_sel_i    (wb_sel_i),
        .wb_burst8_i (wb_burst8_i),
        .wb_burst4_i (wb_burst4_i),
        .hdr_o       (hdr),
        .adr_lo_o    (adr_lo),
        .last_beat_o (last_beat)
    );

    cw_burst_tracker u_burst_tracker (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .start_i     (start),
        .beat_i      (beat),
        .wb_adr_i    (wb_adr_i),
        .last_beat_i (last_beat),
        .last_o      (last),
        .mismatch_o  (mismatch)
    );

    cw_bridge_ctrl u_bridge_ctrl (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .wb_cyc_i   (wb_cyc_i),
        .wb_stb_i   (wb_stb_i),
        .wb_we_i    (wb_we_i),
        .wb_dat_i   (wb_dat_i),
        .hdr_i      (hdr),
        .adr_lo_i   (adr_lo),
        .last_i     (last),
        .mismatch_i (mismatch),
        .wb_dat_o   (wb_dat_o),
        .wb_ack_o   (wb_ack_o),
        .wb_err_o   (wb_err_o),
        .start_o    (start),
        .beat_o     (beat),
        .link       (link_if.master)
    );

    // far side of the link
    cw_remote_endpoint u_remote_endpoint (
        .i_clk (i_clk),
        .i_rst (i_rst),
        .link  (link_if.slave)
    );

endmodule

`default_nettype wire

//--- logic/cw_burst_tracker.sv
`default_nettype none

module cw_burst_tracker (
    input  logic              i_clk,
    input  logic              i_rst,
    input  logic              start_i,
    input  logic              beat_i,
    input  cw_pkg::wb_addr_t  wb_adr_i,
    input  cw_pkg::beat_cnt_t last_beat_i,
    output logic              last_o,
    output logic              mismatch_o
);
    import cw_pkg::*;

    wb_addr_t  start_adr;
    wb_addr_t  exp_adr;
    beat_cnt_t beat_cnt;
    beat_cnt_t last_idx;

    // beat counter
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            beat_cnt <= '0;
        end else if (start_i) begin
            beat_cnt <= '0;
        end else if (beat_i) begin
            beat_cnt <= beat_cnt + 1'b1;       // wraps harmlessly after the last beat
        end
    end

    // start address and burst length, held for the whole cycle
    always_ff @(posedge i_clk) begin
        if (start_i) begin
            start_adr <= wb_adr_i;
            last_idx  <= last_beat_i;
        end
    end

    assign exp_adr    = start_adr + wb_addr_t'(beat_cnt);
    assign mismatch_o = (wb_adr_i != exp_adr);   // master left the linear sequence
    assign last_o     = (beat_cnt == last_idx);

endmodule

`default_nettype wire

//--- logic/cw_header_pack.sv
`default_nettype none

module cw_header_pack (
    input  cw_pkg::wb_addr_t  wb_adr_i,
    input  logic              wb_we_i,
    input  cw_pkg::sel_t      wb_sel_i,
    input  logic              wb_burst8_i,
    input  logic              wb_burst4_i,
    output cw_pkg::word_t     hdr_o,
    output cw_pkg::word_t     adr_lo_o,
    output cw_pkg::beat_cnt_t last_beat_o
);
    import cw_pkg::*;

    logic [HDR_TYPE_W-1:0] cyc_type;

    always_comb begin
        if (wb_burst8_i) begin             // 8 wins when both are set
            cyc_type = CYC_BURST8;
        end else if (wb_burst4_i) begin
            cyc_type = CYC_BURST4;
        end else begin
            cyc_type = CYC_SINGLE;
        end
    end

    always_comb begin
        hdr_o = '0;
        hdr_o[HDR_ADR_LSB +: HDR_ADR_HI_W] = wb_adr_i[WB_ADDR_W-1 -: HDR_ADR_HI_W];
        hdr_o[HDR_TYPE_LSB +: HDR_TYPE_W]  = cyc_type;
        hdr_o[HDR_WE_BIT]                  = wb_we_i;
        hdr_o[HDR_SEL_LSB +: SEL_W]        = wb_sel_i;
        hdr_o[HDR_VALID_BIT]               = 1'b1;
    end

    assign adr_lo_o    = wb_adr_i[RW-1:0];      // second link word
    assign last_beat_o = burst_last(cyc_type);

endmodule

`default_nettype wire

//--- logic/cw_link_if.sv
`default_nettype none

interface cw_link_if;
    import cw_pkg::*;

    logic  req;        // one-cycle request strobe
    logic  dir;        // high while the endpoint drives data
    word_t dat_m;      // bridge to endpoint
    word_t dat_s;      // endpoint to bridge
    logic  ack;
    logic  err;

    modport master (
        output req,
        output dir,
        output dat_m,
        input  dat_s,
        input  ack,
        input  err
    );

    modport slave (
        input  req,
        input  dir,
        input  dat_m,
        output dat_s,
        output ack,
        output err
    );

endinterface

`default_nettype wire

//--- logic/cw_pkg.sv
`default_nettype none

package cw_pkg;

    // ======================================================================
    // widths and word types
    // ======================================================================
    localparam int WB_ADDR_W    = 24;
    localparam int RW           = 16;                // link and data word
    localparam int MAX_BRST_LOG = 3;
    localparam int SEL_W        = 2;
    localparam int LANE_W       = RW / SEL_W;        // one byte lane

    typedef logic [WB_ADDR_W-1:0]    wb_addr_t;
    typedef logic [RW-1:0]           word_t;
    typedef logic [MAX_BRST_LOG-1:0] beat_cnt_t;
    typedef logic [SEL_W-1:0]        sel_t;

    // ======================================================================
    // header word layout  {adr_hi, type, we, sel, valid}
    // ======================================================================
    localparam int HDR_ADR_HI_W  = WB_ADDR_W - RW;
    localparam int HDR_ADR_LSB   = RW - HDR_ADR_HI_W;
    localparam int HDR_TYPE_W    = 4;
    localparam int HDR_TYPE_LSB  = 4;
    localparam int HDR_WE_BIT    = 3;
    localparam int HDR_SEL_LSB   = 1;
    localparam int HDR_VALID_BIT = 0;                // always set by the bridge

    localparam logic [HDR_TYPE_W-1:0] CYC_SINGLE = 4'b0000;
    localparam logic [HDR_TYPE_W-1:0] CYC_BURST8 = 4'b0001;
    localparam logic [HDR_TYPE_W-1:0] CYC_BURST4 = 4'b0010;

    localparam beat_cnt_t LAST_BURST8 = 3'd7;        // index of the final beat
    localparam beat_cnt_t LAST_BURST4 = 3'd3;

    // remote memory
    localparam int MEM_DEPTH = 256;
    localparam int MEM_ADR_W = $clog2(MEM_DEPTH);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_HDR,
        ST_ADR,
        ST_WACK,
        ST_DATA_W,
        ST_DATA_WT,
        ST_DATA_R,
        ST_DONE
    } cw_state_e;

    // final beat index carried by a cycle type code
    function automatic beat_cnt_t burst_last(input logic [HDR_TYPE_W-1:0] cyc_type);
        case (cyc_type)
            CYC_BURST8: return LAST_BURST8;
            CYC_BURST4: return LAST_BURST4;
            default:    return '0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- logic/cw_remote_endpoint.sv
`default_nettype none

module cw_remote_endpoint (
    input  logic       i_clk,
    input  logic       i_rst,
    cw_link_if.slave   link
);
    import cw_pkg::*;

    typedef enum logic [1:0] {
        EP_IDLE,
        EP_ADR,
        EP_WR,
        EP_RD
    } ep_state_e;

    ep_state_e ep_state;

    word_t                   mem [MEM_DEPTH];
    logic [HDR_ADR_HI_W-1:0] adr_hi;
    logic                    l_we;
    sel_t                    l_sel;
    beat_cnt_t               l_last;
    logic [MEM_ADR_W-1:0]    mem_adr;
    logic                    phase;           // read pacing, send when set
    wb_addr_t                full_adr;
    logic [WB_ADDR_W:0]      end_adr;         // one extra bit so the sum cannot wrap
    logic                    wr_beat;
    logic                    rd_beat;

    assign full_adr = {adr_hi, link.dat_m};
    assign end_adr  = {1'b0, full_adr} + (WB_ADDR_W + 1)'(l_last);
    assign wr_beat  = (ep_state == EP_WR) && !link.dir && link.req;
    assign rd_beat  = (ep_state == EP_RD) && phase && link.dir;

    // ======================================================================
    // control
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            ep_state <= EP_IDLE;
            link.ack <= 1'b0;
            link.err <= 1'b0;
            phase    <= 1'b0;
        end else begin
            link.ack <= 1'b0;
            link.err <= 1'b0;

            case (ep_state)
                EP_IDLE: begin
                    if (link.req && link.dat_m[HDR_VALID_BIT]) begin
                        ep_state <= EP_ADR;
                    end
                end
                EP_ADR: begin
                    phase <= 1'b0;
                    // whole burst must fit below MEM_DEPTH
                    if (end_adr >= (WB_ADDR_W + 1)'(MEM_DEPTH)) begin
                        link.err <= 1'b1;
                        ep_state <= EP_IDLE;
                    end else begin
                        link.ack <= 1'b1;             // ready
                        ep_state <= l_we ? EP_WR : EP_RD;
                    end
                end
                EP_WR: begin
                    if (link.dir) begin               // turnaround from the bridge
                        ep_state <= EP_IDLE;
                    end else if (wr_beat) begin
                        link.ack <= 1'b1;
                    end
                end
                EP_RD: begin
                    phase <= ~phase;
                    if (rd_beat) begin
                        link.ack <= 1'b1;
                    end else if (phase) begin         // bridge released dir
                        ep_state <= EP_IDLE;
                    end
                end
                default: begin
                    ep_state <= EP_IDLE;
                end
            endcase
        end
    end

    // ======================================================================
    // header capture, memory and address stepping
    // ======================================================================
    always_ff @(posedge i_clk) begin
        if ((ep_state == EP_IDLE) && link.req) begin
            adr_hi <= link.dat_m[HDR_ADR_LSB +: HDR_ADR_HI_W];
            l_we   <= link.dat_m[HDR_WE_BIT];
            l_sel  <= link.dat_m[HDR_SEL_LSB +: SEL_W];
            l_last <= burst_last(link.dat_m[HDR_TYPE_LSB +: HDR_TYPE_W]);
        end

        if (ep_state == EP_ADR) begin
            mem_adr <= full_adr[MEM_ADR_W-1:0];
        end

        if (wr_beat) begin
            for (int i = 0; i < SEL_W; i++) begin
                if (l_sel[i]) begin
                    mem[mem_adr][LANE_W*i +: LANE_W] <= link.dat_m[LANE_W*i +: LANE_W];
                end
            end
            mem_adr <= mem_adr + 1'b1;
        end

        if (rd_beat) begin
            link.dat_s <= mem[mem_adr];
            mem_adr    <= mem_adr + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cw_bridge_tb \
    -f cw_bridge_top.f \
    -o cw_bridge_sim

./obj_dir/cw_bridge_sim | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

//--- sim/cw_bridge_assert.sv
`default_nettype none

module cw_bridge_assert (
    input logic              i_clk,
    input logic              i_rst,
    input logic              wb_ack_i,
    input logic              wb_err_i,
    input logic              req_i,
    input logic              dir_i,
    input cw_pkg::cw_state_e state_i
);
    import cw_pkg::*;

    ack_err_excl: assert property (@(posedge i_clk) disable iff (i_rst)
        !(wb_ack_i && wb_err_i))
        else $error("wb_ack_o and wb_err_o high in the same cycle");

    req_pulse: assert property (@(posedge i_clk) disable iff (i_rst)
        req_i |=> !req_i)
        else $error("link req held for more than one cycle");

    // endpoint owns the data lines during reads and the turnaround after a write
    dir_owner: assert property (@(posedge i_clk) disable iff (i_rst)
        dir_i |-> (state_i == ST_DATA_R || state_i == ST_DONE))
        else $error("link dir high outside the read states");

    ack_after_rst: assert property (@(posedge i_clk)
        i_rst |=> (!wb_ack_i && !wb_err_i))
        else $error("wb_ack_o or wb_err_o high right after reset");

endmodule

bind cw_bridge_top cw_bridge_assert u_bridge_assert (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .wb_ack_i (wb_ack_o),
    .wb_err_i (wb_err_o),
    .req_i    (link_if.req),
    .dir_i    (link_if.dir),
    .state_i  (u_bridge_ctrl.state)
);

`default_nettype wire

//--- sim/cw_bridge_tb.sv
`default_nettype none

module cw_bridge_tb;
    import cw_pkg::*;

    localparam int TIMEOUT_CYC = 200;

    logic     i_clk;
    logic     i_rst;
    logic     wb_cyc_i;
    logic     wb_stb_i;
    logic     wb_we_i;
    wb_addr_t wb_adr_i;
    word_t    wb_dat_i;
    sel_t     wb_sel_i;
    logic     wb_burst8_i;
    logic     wb_burst4_i;
    word_t    wb_dat_o;
    logic     wb_ack_o;
    logic     wb_err_o;

    integer seed = 32'h1992437c;
    word_t  model [MEM_DEPTH];       // expected remote memory contents
    word_t  wr_data [8];
    word_t  rd_data [8];
    int     n_acked;                 // beats acked in the last cycle
    logic   got_err;
    logic   hung;
    int     errors;
    int     tests;
    int     failed_tests;

    cw_bridge_top cw_bridge_top_inst (.*);

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // ======================================================================
    // reference model and checks
    // ======================================================================
    function automatic word_t lane_merge(word_t old_w, word_t new_w, sel_t sel);
        return {sel[1] ? new_w[15:8] : old_w[15:8], sel[0] ? new_w[7:0] : old_w[7:0]};
    endfunction

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (!hung) begin
            assert (act == exp) else begin
                $display("Error %s: expected %h, actual %h", name, exp, act);
                errors++;
            end
        end
    endtask

    task automatic check_err(input string name, input int exp_acks);
        check_word({name, " err"}, 16'd1, word_t'(got_err));
        check_word({name, " acks"}, word_t'(exp_acks), word_t'(n_acked));
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before && !hung) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: failed", name);
        end
    endtask

    // ======================================================================
    // wishbone master
    // ======================================================================
    task automatic run_cycle(input logic we, input wb_addr_t adr, input int beats,
                             input logic b8, input logic b4, input sel_t sel,
                             input int bad_beat);
        int   beat;
        int   wait_cnt;
        logic done;
        if (hung) return;
        beat    = 0;
        done    = 1'b0;
        got_err = 1'b0;
        n_acked = 0;
        @(posedge i_clk);
        wb_cyc_i    <= 1'b1;
        wb_stb_i    <= 1'b1;
        wb_we_i     <= we;
        wb_adr_i    <= adr;
        wb_dat_i    <= wr_data[0];
        wb_sel_i    <= sel;
        wb_burst8_i <= b8;
        wb_burst4_i <= b4;
        while (!done) begin
            wait_cnt = 0;
            @(negedge i_clk);
            while (!wb_ack_o && !wb_err_o && wait_cnt < TIMEOUT_CYC) begin
                wait_cnt++;
                @(negedge i_clk);
            end
            if (wait_cnt >= TIMEOUT_CYC) begin
                $display("timeout: beat %0d of cycle at %h got neither ack nor err", beat, adr);
                errors++;
                hung = 1'b1;
                done = 1'b1;
            end else if (wb_err_o) begin
                got_err = 1'b1;
                done    = 1'b1;
            end else begin
                rd_data[beat] = wb_dat_o;
                n_acked++;
                beat++;
                done = (beat == beats);
            end
            @(posedge i_clk);
            if (done) begin
                wb_cyc_i <= 1'b0;
                wb_stb_i <= 1'b0;
            end else begin
                if (we) begin
                    wb_stb_i <= 1'b0;        // write resync gap
                    @(posedge i_clk);
                    wb_stb_i <= 1'b1;
                    wb_dat_i <= wr_data[beat];
                end
                wb_adr_i <= adr + wb_addr_t'((beat == bad_beat) ? beat + 5 : beat);
            end
        end
    endtask

    task automatic fill_data(input int beats);
        for (int i = 0; i < beats; i++) begin
            wr_data[i] = word_t'($random(seed));
        end
    endtask

    // a burst past the memory end is refused whole, a stray address stops at that beat
    task automatic write_words(input string name, input wb_addr_t adr, input int beats,
                               input logic b8, input logic b4, input sel_t sel,
                               input int bad_beat);
        int exp_acks;
        exp_acks = beats;
        if (int'(adr) + beats > MEM_DEPTH) begin
            exp_acks = 0;
        end else if (bad_beat >= 0 && bad_beat < beats) begin
            exp_acks = bad_beat;
        end
        run_cycle(1'b1, adr, beats, b8, b4, sel, bad_beat);
        check_word({name, " acks"}, word_t'(exp_acks), word_t'(n_acked));
        check_word({name, " err"}, word_t'(exp_acks != beats), word_t'(got_err));
        for (int i = 0; i < exp_acks; i++) begin
            model[int'(adr) + i] = lane_merge(model[int'(adr) + i], wr_data[i], sel);
        end
    endtask

    task automatic read_compare(input string name, input wb_addr_t adr, input int beats,
                                input logic b8, input logic b4);
        run_cycle(1'b0, adr, beats, b8, b4, 2'b11, -1);
        check_word({name, " acks"}, word_t'(beats), word_t'(n_acked));
        for (int i = 0; i < n_acked; i++) begin
            check_word(name, model[int'(adr) + i], rd_data[i]);
        end
    endtask

    // ======================================================================
    // test sequence
    // ======================================================================
    initial begin
        int e0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        hung         = 1'b0;
        i_rst        = 1'b1;
        wb_cyc_i     = 1'b0;
        wb_stb_i     = 1'b0;
        wb_we_i      = 1'b0;
        wb_adr_i     = '0;
        wb_dat_i     = '0;
        wb_sel_i     = '0;
        wb_burst8_i  = 1'b0;
        wb_burst4_i  = 1'b0;
        repeat (8) @(posedge i_clk);
        i_rst <= 1'b0;

        e0 = errors;
        fill_data(1);
        write_words("single_wr", 24'h000010, 1, 1'b0, 1'b0, 2'b11, -1);
        read_compare("single", 24'h000010, 1, 1'b0, 1'b0);
        end_test("single", e0);

        e0 = errors;                                  // byte lanes
        fill_data(1);
        write_words("full_wr", 24'h000020, 1, 1'b0, 1'b0, 2'b11, -1);
        fill_data(1);
        write_words("sel_low_wr", 24'h000020, 1, 1'b0, 1'b0, 2'b01, -1);
        read_compare("sel_low", 24'h000020, 1, 1'b0, 1'b0);
        fill_data(1);
        write_words("sel_high_wr", 24'h000020, 1, 1'b0, 1'b0, 2'b10, -1);
        read_compare("sel_high", 24'h000020, 1, 1'b0, 1'b0);
        end_test("byte_select", e0);

        e0 = errors;
        fill_data(4);
        write_words("burst4_wr", 24'h000040, 4, 1'b0, 1'b1, 2'b11, -1);
        read_compare("burst4", 24'h000040, 4, 1'b0, 1'b1);
        end_test("burst4", e0);

        e0 = errors;                                  // both burst inputs high on the write
        fill_data(8);
        write_words("burst8_wr", 24'h000060, 8, 1'b1, 1'b1, 2'b11, -1);
        read_compare("burst8", 24'h000060, 8, 1'b1, 1'b0);
        end_test("burst8", e0);

        e0 = errors;
        fill_data(4);
        write_words("range_fill_wr", 24'h0000fc, 4, 1'b0, 1'b1, 2'b11, -1);
        fill_data(4);
        write_words("range_single_wr", 24'h000100, 1, 1'b0, 1'b0, 2'b11, -1);
        write_words("range_cross_wr", 24'h0000fe, 4, 1'b0, 1'b1, 2'b11, -1);
        run_cycle(1'b0, 24'h000100, 1, 1'b0, 1'b0, 2'b11, -1);
        check_err("range_single_rd", 0);
        read_compare("range_unchanged", 24'h0000fc, 4, 1'b0, 1'b1);
        end_test("out_of_range", e0);

        e0 = errors;                                  // beat 1 leaves the linear sequence
        fill_data(4);
        write_words("mismatch", 24'h000080, 4, 1'b0, 1'b1, 2'b11, 1);
        read_compare("mismatch_beat0", 24'h000080, 1, 1'b0, 1'b0);
        fill_data(1);
        write_words("after_mismatch_wr", 24'h000090, 1, 1'b0, 1'b0, 2'b11, -1);
        read_compare("after_mismatch", 24'h000090, 1, 1'b0, 1'b0);
        end_test("addr_mismatch", e0);

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0 && !hung) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
